//--- bench/udp_tx_trace.txt
// words 0..3: send_enable high, low, high phase lengths in blocks of 8 cycles, spare
// then per frame: 42 header bytes (two lines of 21) and 18 payload bytes, frames 0 to 3
32 19 64 00
// frame 0, identification 0, ip checksum b66f
02 00 00 00 00 02 02 00 00 00 00 01 08 00 45 00 00 2e 00 00 40
00 40 11 b6 6f c0 a8 01 80 c0 a8 01 7f 0b b9 0b b8 00 1a 00 00
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
// frame 1, identification 1, ip checksum b66e
02 00 00 00 00 02 02 00 00 00 00 01 08 00 45 00 00 2e 00 01 40
00 40 11 b6 6e c0 a8 01 80 c0 a8 01 7f 0b b9 0b b8 00 1a 00 00
12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23
// frame 2, identification 2, ip checksum b66d
02 00 00 00 00 02 02 00 00 00 00 01 08 00 45 00 00 2e 00 02 40
00 40 11 b6 6d c0 a8 01 80 c0 a8 01 7f 0b b9 0b b8 00 1a 00 00
24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35
// frame 3, identification 3, ip checksum b66c
02 00 00 00 00 02 02 00 00 00 00 01 08 00 45 00 00 2e 00 03 40
00 40 11 b6 6c c0 a8 01 80 c0 a8 01 7f 0b b9 0b b8 00 1a 00 00
36 37 38 39 3a 3b 3c 3d 3e 3f 40 41 42 43 44 45 46 47

//--- files.f
hdl/udp_tx_pkg.sv
hdl/udp_payload_gen.sv
hdl/ip_udp_header_gen.sv
hdl/mii_tx_mac.sv
hdl/udp_tx_top.sv
bench/udp_tx_asserts.sv
bench/udp_tx_checker.sv
bench/udp_tx_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = udp_tx_tb
FILELIST = files.f
OBJDIR   = obj_dir
PASS     = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)

//--- bench/udp_tx_tb.sv
`timescale 1ns/1ps

module udp_tx_tb
    import udp_tx_pkg::*;
;

    // payload length matches the udp_tx_top default
    localparam int PAYLOAD_LEN = 18;
    localparam int SCHED_WORDS = 4;
    localparam int FRAME_WORDS = HDR_BYTES + PAYLOAD_LEN;
    localparam int NUM_FRAMES = 4;
    localparam int TRACE_LEN = SCHED_WORDS + NUM_FRAMES * FRAME_WORDS;
    // schedule entries count blocks of this many cycles
    localparam int SCHED_UNIT = 8;
    localparam int RUN_LIMIT = 6000;

    logic udp_sys_clk;
    logic rst;
    logic send_enable;
    logic [3:0] mii_txd;
    logic mii_tx_en;

    byte_t trace_mem [TRACE_LEN];

    int check_errors;
    logic check_done;
    int run_cycles;

    // 4 ns clock
    initial begin
        udp_sys_clk = 1'b0;
        forever #2 udp_sys_clk = ~udp_sys_clk;
    end

    udp_tx_top udp_tx_top_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .send_enable(send_enable),
        .mii_txd(mii_txd),
        .mii_tx_en(mii_tx_en)
    );

    udp_tx_checker #(
        .PAYLOAD_LEN(PAYLOAD_LEN),
        .SCHED_WORDS(SCHED_WORDS),
        .NUM_FRAMES(NUM_FRAMES),
        .TRACE_LEN(TRACE_LEN)
    ) udp_tx_checker_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .send_enable(send_enable),
        .mii_txd(mii_txd),
        .mii_tx_en(mii_tx_en),
        .trace_mem(trace_mem),
        .errors(check_errors),
        .done(check_done)
    );

    // reset, then the enable schedule from the trace
    initial begin
        rst = 1'b1;
        send_enable = 1'b0;
        $readmemh("bench/udp_tx_trace.txt", trace_mem);
        repeat (3) @(posedge udp_sys_clk);
        rst <= 1'b0;
        // high, low, high phases
        send_enable <= 1'b1;
        repeat (int'(trace_mem[0]) * SCHED_UNIT) @(posedge udp_sys_clk);
        send_enable <= 1'b0;
        repeat (int'(trace_mem[1]) * SCHED_UNIT) @(posedge udp_sys_clk);
        send_enable <= 1'b1;
        repeat (int'(trace_mem[2]) * SCHED_UNIT) @(posedge udp_sys_clk);
        send_enable <= 1'b0;
    end

    // run until the checker has seen every frame, bounded
    initial begin
        run_cycles = 0;
        @(negedge udp_sys_clk);
        while (!check_done && run_cycles < RUN_LIMIT) begin
            @(negedge udp_sys_clk);
            run_cycles++;
        end
        if (!check_done) begin
            $display("checker did not finish within %0d cycles", RUN_LIMIT);
            $display("errors: %0d", check_errors);
            $display("Errors found");
        end else begin
            $display("errors: %0d", check_errors);
            if (check_errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
        end
        $finish;
    end

endmodule

//--- bench/udp_tx_checker.sv
`timescale 1ns/1ps

module udp_tx_checker
    import udp_tx_pkg::*;
#(
    parameter int PAYLOAD_LEN = 18,
    parameter int SCHED_WORDS = 4,
    parameter int NUM_FRAMES = 4,
    parameter int TRACE_LEN = 244
) (
    input var logic udp_sys_clk,
    input var logic rst,
    input var logic send_enable,
    input var logic [3:0] mii_txd,
    input var logic mii_tx_en,
    input var byte_t trace_mem [TRACE_LEN],
    output int errors,
    output logic done
);

    localparam int FRAME_WORDS = HDR_BYTES + PAYLOAD_LEN;
    localparam int WIRE_BYTES = PREAMBLE_BYTES + 1 + FRAME_WORDS + FCS_BYTES;
    localparam int START_TIMEOUT = 400;
    // a frame committed just before enable drops may still start this late
    localparam int LATE_START = 40;

    int seq_errors;
    int mon_errors;
    logic [3:0] nibs [2 * WIRE_BYTES + 64];
    byte_t exp_bytes [WIRE_BYTES];
    int low_run;
    int idle_len;
    logic prev_en;
    logic seen_frame;

    assign errors = seq_errors + mon_errors;

    // reflected crc-32 computed one bit at a time
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input byte_t b);
        logic [31:0] c;
        logic fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hEDB8_8320;
            end
        end
        return c;
    endfunction

    // expected wire bytes of frame k as preamble, trace bytes and fcs
    task automatic build_expected(input int k);
        logic [31:0] crc;
        int base;
        base = SCHED_WORDS + k * FRAME_WORDS;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < PREAMBLE_BYTES; i++) begin
            exp_bytes[i] = 8'h55;
        end
        exp_bytes[PREAMBLE_BYTES] = 8'hD5;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            exp_bytes[PREAMBLE_BYTES + 1 + i] = trace_mem[base + i];
            crc = crc_step(crc, trace_mem[base + i]);
        end
        crc = ~crc;
        // least significant byte first
        for (int i = 0; i < FCS_BYTES; i++) begin
            exp_bytes[PREAMBLE_BYTES + 1 + FRAME_WORDS + i] = crc[8 * i +: 8];
        end
    endtask

    // frame reassembly sampled on the falling edge where outputs are settled
    initial begin
        int t;
        int nib_cnt;
        byte_t got;
        seq_errors = 0;
        done = 1'b0;
        @(negedge udp_sys_clk);
        t = 0;
        while (rst && t < START_TIMEOUT) begin
            @(negedge udp_sys_clk);
            t++;
        end
        if (rst) begin
            $display("reset still asserted after timeout");
            seq_errors++;
        end
        for (int k = 0; k < NUM_FRAMES; k++) begin
            t = 0;
            while (!mii_tx_en && t < START_TIMEOUT) begin
                @(negedge udp_sys_clk);
                t++;
            end
            if (!mii_tx_en) begin
                $display("no frame started before timeout");
                seq_errors++;
                break;
            end
            nib_cnt = 0;
            while (mii_tx_en && nib_cnt < 2 * WIRE_BYTES + 64) begin
                nibs[nib_cnt] = mii_txd;
                nib_cnt++;
                @(negedge udp_sys_clk);
            end
            if (nib_cnt != 2 * WIRE_BYTES) begin
                $display("Error: time %0t signal mii_tx_en frame %0d expected %0d actual %0d",
                    $time, k, 2 * WIRE_BYTES, nib_cnt);
                seq_errors++;
            end
            build_expected(k);
            for (int i = 0; i < WIRE_BYTES; i++) begin
                // low nibble went out first
                got = {nibs[2 * i + 1], nibs[2 * i]};
                if (got !== exp_bytes[i]) begin
                    $display(
                        "Error: time %0t signal mii_txd frame %0d byte %0d expected %h actual %h",
                        $time, k, i, exp_bytes[i], got);
                    seq_errors++;
                end
            end
        end
        done = 1'b1;
    end

    // line rules and enable gating checked every cycle
    always @(negedge udp_sys_clk) begin
        if (rst) begin
            mon_errors = 0;
            low_run = 0;
            idle_len = 0;
            prev_en = 1'b0;
            seen_frame = 1'b0;
        end else begin
            if (!mii_tx_en && mii_txd != 4'h0) begin
                $display("Error: time %0t signal mii_txd expected 0 actual %h", $time, mii_txd);
                mon_errors++;
            end
            if (mii_tx_en && !prev_en) begin
                if (low_run > LATE_START) begin
                    $display("a frame started while send_enable had been low for %0d cycles",
                        low_run);
                    mon_errors++;
                end
                if (seen_frame && idle_len < IFG_NIBBLES) begin
                    $display("Error: time %0t signal mii_tx_en gap expected >= %0d actual %0d",
                        $time, IFG_NIBBLES, idle_len);
                    mon_errors++;
                end
            end
            idle_len = mii_tx_en ? 0 : idle_len + 1;
            low_run = send_enable ? 0 : low_run + 1;
            seen_frame = seen_frame || mii_tx_en;
            prev_en = mii_tx_en;
        end
    end

endmodule

//--- bench/udp_tx_asserts.sv
`timescale 1ns/1ps

module udp_tx_asserts (
    input var logic udp_sys_clk,
    input var logic rst,
    input var logic [3:0] mii_txd,
    input var logic mii_tx_en
);

    // 2 x (8 + 42 + 18 + 4) nibbles per frame
    localparam int FRAME_NIBBLES = 144;
    localparam int MIN_GAP = 24;

    int en_len;
    int idle_len;
    logic seen_frame;

    always_ff @(posedge udp_sys_clk) begin
        if (rst) begin
            en_len <= 0;
            idle_len <= 0;
            seen_frame <= 1'b0;
        end else begin
            en_len <= mii_tx_en ? en_len + 1 : 0;
            idle_len <= mii_tx_en ? 0 : idle_len + 1;
            if (mii_tx_en) begin
                seen_frame <= 1'b1;
            end
        end
    end

    // line stays quiet between frames
    idle_txd_zero: assert property (@(posedge udp_sys_clk) disable iff (rst)
        !mii_tx_en |-> mii_txd == 4'h0)
        else $error("mii_txd not zero while mii_tx_en is low");

    frame_length: assert property (@(posedge udp_sys_clk) disable iff (rst)
        $fell(mii_tx_en) |-> en_len == FRAME_NIBBLES)
        else $error("mii_tx_en high for %0d cycles", en_len);

    interframe_gap: assert property (@(posedge udp_sys_clk) disable iff (rst)
        ($rose(mii_tx_en) && seen_frame) |-> idle_len >= MIN_GAP)
        else $error("interframe gap of %0d cycles", idle_len);

endmodule

bind udp_tx_top udp_tx_asserts udp_tx_asserts_inst (
    .udp_sys_clk(udp_sys_clk),
    .rst(rst),
    .mii_txd(mii_txd),
    .mii_tx_en(mii_tx_en)
);

//--- hdl/udp_tx_top.sv
`default_nettype none
`timescale 1ns / 1ps

module udp_tx_top
    import udp_tx_pkg::*;
#(
    parameter logic [47:0] SRC_MAC = 48'h02_00_00_00_00_01,
    parameter logic [47:0] DST_MAC = 48'h02_00_00_00_00_02,
    parameter logic [31:0] SRC_IP = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter logic [31:0] DST_IP = {8'd192, 8'd168, 8'd1, 8'd127},
    parameter logic [15:0] SRC_PORT = 16'd3001,
    parameter logic [15:0] DST_PORT = 16'd3000,
    parameter logic [7:0] TTL = 8'd64,
    // must stay at 18 or more so no padding is needed
    parameter int PAYLOAD_LEN = 18
) (
    input var logic udp_sys_clk,
    input var logic rst,
    input var logic send_enable,
    output logic [3:0] mii_txd,
    output logic mii_tx_en
);

    // payload stream
    byte_t pay_data;
    logic pay_last;
    logic pay_valid;
    logic pay_ready;

    // framed stream into the mac
    byte_t frm_data;
    logic frm_last;
    logic frm_valid;
    logic frm_ready;

    udp_payload_gen #(
        .PAYLOAD_LEN(PAYLOAD_LEN)
    ) udp_payload_gen_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .pay_data(pay_data),
        .pay_last(pay_last),
        .pay_valid(pay_valid),
        .pay_ready(pay_ready)
    );

    ip_udp_header_gen #(
        .SRC_MAC(SRC_MAC),
        .DST_MAC(DST_MAC),
        .SRC_IP(SRC_IP),
        .DST_IP(DST_IP),
        .SRC_PORT(SRC_PORT),
        .DST_PORT(DST_PORT),
        .TTL(TTL),
        .PAYLOAD_LEN(PAYLOAD_LEN)
    ) ip_udp_header_gen_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .send_enable(send_enable),
        .pay_data(pay_data),
        .pay_last(pay_last),
        .pay_valid(pay_valid),
        .pay_ready(pay_ready),
        .frm_data(frm_data),
        .frm_last(frm_last),
        .frm_valid(frm_valid),
        .frm_ready(frm_ready)
    );

    mii_tx_mac mii_tx_mac_inst (
        .udp_sys_clk(udp_sys_clk),
        .rst(rst),
        .frm_data(frm_data),
        .frm_last(frm_last),
        .frm_valid(frm_valid),
        .frm_ready(frm_ready),
        .mii_txd(mii_txd),
        .mii_tx_en(mii_tx_en)
    );

endmodule

`default_nettype wire

//--- hdl/mii_tx_mac.sv
`default_nettype none
`timescale 1ns / 1ps

module mii_tx_mac
    import udp_tx_pkg::*;
(
    input var logic udp_sys_clk,
    input var logic rst,
    input var byte_t frm_data,
    input var logic frm_last,
    input var logic frm_valid,
    output logic frm_ready,
    output logic [3:0] mii_txd,
    output logic mii_tx_en
);

    // one counter shared by preamble, fcs and gap, sized for the longest
    localparam int CNT_W = $clog2(IFG_NIBBLES);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_FCS,
        ST_GAP
    } state_t;

    state_t state;
    logic [CNT_W-1:0] cnt;
    logic nib_hi;
    byte_t tx_byte;
    logic tx_last;
    logic [31:0] crc;
    logic [31:0] fcs;
    byte_t pre_byte;
    logic frm_fire;

    // fetch a byte on the last preamble nibble and on every high data nibble
    always_comb begin
        frm_ready = 1'b0;
        case (state)
            ST_PREAMBLE: frm_ready = (cnt == CNT_W'(PREAMBLE_NIBBLES - 1));
            ST_DATA: frm_ready = nib_hi && !tx_last;
            default: frm_ready = 1'b0;
        endcase
    end

    assign frm_fire = frm_valid && frm_ready;

    // fcs goes out inverted
    assign fcs = ~crc;

    // 0x55 for the first seven bytes, then the sfd
    assign pre_byte = (cnt < CNT_W'(2 * PREAMBLE_BYTES)) ? PREAMBLE_BYTE : SFD_BYTE;

    // nibble mux, low nibble of each byte first
    always_comb begin
        mii_tx_en = 1'b0;
        mii_txd = 4'h0;
        case (state)
            ST_PREAMBLE: begin
                mii_tx_en = 1'b1;
                mii_txd = cnt[0] ? pre_byte[7:4] : pre_byte[3:0];
            end
            ST_DATA: begin
                mii_tx_en = 1'b1;
                mii_txd = nib_hi ? tx_byte[7:4] : tx_byte[3:0];
            end
            ST_FCS: begin
                // least significant byte first falls out of nibble order
                mii_tx_en = 1'b1;
                mii_txd = fcs[4 * cnt[2:0] +: 4];
            end
            default: ;
        endcase
    end

    always_ff @(posedge udp_sys_clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt <= '0;
            nib_hi <= 1'b0;
            tx_last <= 1'b0;
            crc <= CRC32_INIT;
        end else begin
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    crc <= CRC32_INIT;
                    if (frm_valid) begin
                        state <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    if (frm_fire) begin
                        state <= ST_DATA;
                        nib_hi <= 1'b0;
                    end else if (cnt != CNT_W'(PREAMBLE_NIBBLES - 1)) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (!nib_hi) begin
                        nib_hi <= 1'b1;
                    end else if (tx_last) begin
                        // last high nibble, crc already holds every byte
                        state <= ST_FCS;
                        cnt <= '0;
                    end else if (frm_fire) begin
                        nib_hi <= 1'b0;
                    end
                end
                ST_FCS: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(FCS_NIBBLES - 1)) begin
                        state <= ST_GAP;
                        cnt <= '0;
                    end
                end
                ST_GAP: begin
                    // interframe gap before the next preamble
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(IFG_NIBBLES - 1)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            // each accepted byte enters the running crc
            if (frm_fire) begin
                crc <= crc32_update(crc, frm_data);
                tx_last <= frm_last;
            end
        end
    end

    // byte being shifted out
    always_ff @(posedge udp_sys_clk) begin
        if (frm_fire) begin
            tx_byte <= frm_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ip_udp_header_gen.sv
`default_nettype none
`timescale 1ns / 1ps

module ip_udp_header_gen
    import udp_tx_pkg::*;
#(
    parameter logic [47:0] SRC_MAC = 48'h02_00_00_00_00_01,
    parameter logic [47:0] DST_MAC = 48'h02_00_00_00_00_02,
    parameter logic [31:0] SRC_IP = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter logic [31:0] DST_IP = {8'd192, 8'd168, 8'd1, 8'd127},
    parameter logic [15:0] SRC_PORT = 16'd3001,
    parameter logic [15:0] DST_PORT = 16'd3000,
    parameter logic [7:0] TTL = 8'd64,
    parameter int PAYLOAD_LEN = 18
) (
    input var logic udp_sys_clk,
    input var logic rst,
    input var logic send_enable,
    input var byte_t pay_data,
    input var logic pay_last,
    input var logic pay_valid,
    output logic pay_ready,
    output byte_t frm_data,
    output logic frm_last,
    output logic frm_valid,
    input var logic frm_ready
);

    localparam int IDX_W = $clog2(HDR_BYTES);
    localparam logic [15:0] IP_TOTAL_LEN = 16'(IP_HDR_BYTES + UDP_HDR_BYTES + PAYLOAD_LEN);
    localparam logic [15:0] UDP_LEN = 16'(UDP_HDR_BYTES + PAYLOAD_LEN);

    typedef enum logic [1:0] {ST_IDLE, ST_HEADER, ST_PAYLOAD} state_t;

    state_t state;
    logic [IDX_W-1:0] hdr_idx;
    logic [15:0] ip_ident;
    logic [15:0] ip_csum;
    logic [15:0] csum_next;
    logic [31:0] csum_acc;
    logic [HDR_BYTES*8-1:0] hdr_vec;
    logic frm_fire;

    // ipv4 header checksum over all 16-bit words, checksum field taken as zero
    always_comb begin
        csum_acc = 32'h4500 + IP_TOTAL_LEN + ip_ident + 32'h4000;
        csum_acc = csum_acc + {TTL, IP_PROTO_UDP};
        csum_acc = csum_acc + SRC_IP[31:16] + SRC_IP[15:0];
        csum_acc = csum_acc + DST_IP[31:16] + DST_IP[15:0];
        // end-around carry, twice covers any overflow from the first fold
        csum_acc = {16'd0, csum_acc[15:0]} + {16'd0, csum_acc[31:16]};
        csum_acc = {16'd0, csum_acc[15:0]} + {16'd0, csum_acc[31:16]};
        csum_next = ~csum_acc[15:0];
    end

    // whole header, first byte on the wire in the top bits
    assign hdr_vec = {
        DST_MAC, SRC_MAC, ETHERTYPE_IPV4,
        8'h45, 8'h00, IP_TOTAL_LEN, ip_ident, 16'h4000,
        TTL, IP_PROTO_UDP, ip_csum, SRC_IP, DST_IP,
        SRC_PORT, DST_PORT, UDP_LEN, 16'h0000
    };

    assign frm_fire = frm_valid && frm_ready;

    // output mux, payload stream passes straight through in its state
    always_comb begin
        frm_data = pay_data;
        frm_last = 1'b0;
        frm_valid = 1'b0;
        pay_ready = 1'b0;
        case (state)
            ST_HEADER: begin
                frm_data = hdr_vec[(HDR_BYTES - 1 - int'(hdr_idx)) * 8 +: 8];
                frm_valid = 1'b1;
            end
            ST_PAYLOAD: begin
                frm_last = pay_last;
                frm_valid = pay_valid;
                pay_ready = frm_ready;
            end
            default: ;
        endcase
    end

    always_ff @(posedge udp_sys_clk) begin
        if (rst) begin
            state <= ST_IDLE;
            hdr_idx <= '0;
            ip_ident <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    hdr_idx <= '0;
                    if (send_enable) begin
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    // index only moves when the mac takes the byte
                    if (frm_fire) begin
                        if (hdr_idx == IDX_W'(HDR_BYTES - 1)) begin
                            state <= ST_PAYLOAD;
                        end else begin
                            hdr_idx <= hdr_idx + 1'b1;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (frm_fire && pay_last) begin
                        state <= ST_IDLE;
                        ip_ident <= ip_ident + 16'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // checksum is frozen for the frame at its start
    always_ff @(posedge udp_sys_clk) begin
        if (state == ST_IDLE && send_enable) begin
            ip_csum <= csum_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/udp_payload_gen.sv
`default_nettype none
`timescale 1ns / 1ps

module udp_payload_gen
    import udp_tx_pkg::*;
#(
    parameter int PAYLOAD_LEN = 18
) (
    input var logic udp_sys_clk,
    input var logic rst,
    output byte_t pay_data,
    output logic pay_last,
    output logic pay_valid,
    input var logic pay_ready
);

    // position of the current byte inside its datagram
    localparam int CNT_W = $clog2(PAYLOAD_LEN);

    logic [CNT_W-1:0] byte_idx;
    logic pay_fire;

    assign pay_fire = pay_valid && pay_ready;

    // last byte of the datagram, decoded from the index
    assign pay_last = (byte_idx == CNT_W'(PAYLOAD_LEN - 1));

    always_ff @(posedge udp_sys_clk) begin
        if (rst) begin
            pay_valid <= 1'b0;
            pay_data <= '0;
            byte_idx <= '0;
        end else begin
            // source is always ready once out of reset
            pay_valid <= 1'b1;
            if (pay_fire) begin
                // count keeps running across frames, wraps at 255 by width
                pay_data <= pay_data + 8'd1;
                if (pay_last) begin
                    byte_idx <= '0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/udp_tx_pkg.sv
package udp_tx_pkg;

    // one octet on the internal streams
    typedef logic [7:0] byte_t;

    // header sizes of each layer, in bytes
    localparam int ETH_HDR_BYTES = 14;
    localparam int IP_HDR_BYTES = 20;
    localparam int UDP_HDR_BYTES = 8;
    localparam int HDR_BYTES = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;

    // preamble is 7 x 0x55 and then the start frame delimiter
    localparam int PREAMBLE_BYTES = 7;
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE = 8'hD5;

    // frame check sequence length
    localparam int FCS_BYTES = 4;

    // mii moves one nibble per clock
    localparam int PREAMBLE_NIBBLES = 2 * (PREAMBLE_BYTES + 1);
    localparam int FCS_NIBBLES = 2 * FCS_BYTES;
    // minimum idle cycles between two frames (96 bit times)
    localparam int IFG_NIBBLES = 24;

    // protocol field values
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_PROTO_UDP = 8'h11;

    // ethernet crc-32, reflected form
    localparam logic [31:0] CRC32_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC32_POLY = 32'hEDB8_8320;

    // advance the running crc by one byte, lsb first
    function automatic logic [31:0] crc32_update(
        input logic [31:0] crc,
        input byte_t data
    );
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            // shift out one bit and fold in the polynomial when it was set
            if (c[0]) begin
                c = (c >> 1) ^ CRC32_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage
